// File: logic/isa_pkg.sv
package isa_pkg;

    // ************************************************
    // basic word types
    // ************************************************

    typedef logic [31:0] u32_t;
    typedef logic [31:0] virt_t;

    // the major opcode sits in the top six bits of every instruction
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 26;

    typedef logic [OPC_MSB-OPC_LSB:0] opcode_t;

    // ************************************************
    // branch opcodes
    // ************************************************

    localparam opcode_t OP_JIRL = 6'b010011;
    localparam opcode_t OP_B    = 6'b010100;
    localparam opcode_t OP_BL   = 6'b010101;
    localparam opcode_t OP_BEQ  = 6'b010110;
    localparam opcode_t OP_BNE  = 6'b010111;
    localparam opcode_t OP_BLT  = 6'b011000;
    localparam opcode_t OP_BGE  = 6'b011001;
    localparam opcode_t OP_BLTU = 6'b011010;
    localparam opcode_t OP_BGEU = 6'b011011;

    // register numbers used by the return pattern
    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;

    // jirl r0, ra, 0 is the canonical function return
    localparam u32_t INST_RETURN = {OP_JIRL, 16'b0, REG_RA, REG_ZERO};

endpackage

// File: logic/frontend_pkg.sv
package frontend_pkg;

    import isa_pkg::*;

    // ************************************************
    // stage records
    // ************************************************

    typedef struct packed {
        virt_t pc;
        logic  is_predict;
    } next_pc_t;

    typedef struct packed {
        logic     valid;
        virt_t    pc;
        next_pc_t next;
        // set when an AR was issued for this pc and R is still due
        logic     icache_wait_resp;
    } fetch1_fetch2_pass_t;

    typedef struct packed {
        logic     valid;
        virt_t    pc;
        u32_t     inst;
        next_pc_t next;
    } fetch2_decode_pass_t;

    typedef logic [5:0] excp_code_t;

    typedef struct packed {
        logic       valid;
        excp_code_t excp_code;
    } excp_pass_t;

    // fetch address error
    localparam excp_code_t EXCP_ADEF = 6'h08;

    // ************************************************
    // predictor control
    // ************************************************

    typedef struct packed {
        logic  valid;
        virt_t pc;
        logic  is_predict;
    } wr_pc_req_t;

    typedef struct packed {
        logic  valid;
        virt_t pc;
    } btb_invalid_t;

    typedef struct packed {
        logic  valid;
        virt_t pc;
        virt_t target;
    } btb_update_t;

endpackage

// File: logic/fetch_link_if.sv
`timescale 1ns/10ps

interface fetch_link_if import frontend_pkg::*; ();

    // forward hand-off from fetch1
    fetch1_fetch2_pass_t pass;
    excp_pass_t          excp;

    // backward control from fetch2
    logic       stall;
    logic       flush;
    wr_pc_req_t wr_pc_req;

    modport src (
        output pass,
        output excp,
        input  stall,
        input  flush,
        input  wr_pc_req
    );

    modport dst (
        input  pass,
        input  excp,
        output stall,
        output flush,
        output wr_pc_req
    );

endinterface

// File: logic/btb.sv
`timescale 1ns/10ps

module btb import isa_pkg::*, frontend_pkg::*; #(
    parameter int BTB_ENTRIES = 64
) (
    input  logic         clk,
    input  logic         rst_n,
    input  virt_t        lookup_pc_i,
    output logic         hit_o,
    output virt_t        target_o,
    input  btb_update_t  update_i,
    input  btb_invalid_t invalid_i
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W;

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_q [BTB_ENTRIES];
    virt_t                  target_q [BTB_ENTRIES];

    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] update_idx;
    logic [IDX_W-1:0] invalid_idx;
    logic [TAG_W-1:0] lookup_tag;
    logic [TAG_W-1:0] update_tag;

    // bits 1:0 are always zero for an aligned pc
    assign lookup_idx  = lookup_pc_i[IDX_W+1:2];
    assign lookup_tag  = lookup_pc_i[31:IDX_W+2];
    assign update_idx  = update_i.pc[IDX_W+1:2];
    assign update_tag  = update_i.pc[31:IDX_W+2];
    assign invalid_idx = invalid_i.pc[IDX_W+1:2];

    assign hit_o    = valid_q[lookup_idx] & (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

    // invalidate is written last so it wins on a shared index
    always_ff @(posedge clk) begin
        if (~rst_n) begin
            valid_q <= '0;
        end else begin
            if (update_i.valid) begin
                valid_q[update_idx] <= 1'b1;
            end
            if (invalid_i.valid) begin
                valid_q[invalid_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_i.valid) begin
            tag_q[update_idx]    <= update_tag;
            target_q[update_idx] <= update_i.target;
        end
    end

    // fetch2 corrects one instruction per cycle, never both ways at once
    no_update_and_invalid: assert property (@(posedge clk) disable iff (!rst_n)
        !(update_i.valid && invalid_i.valid && update_i.pc == invalid_i.pc));

endmodule

// File: logic/ras.sv
`timescale 1ns/10ps

module ras import isa_pkg::*; #(
    parameter int RAS_DEPTH = 8
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push_i,
    input  virt_t push_pc_i,
    input  logic  pop_i,
    output virt_t ra_o,
    output logic  ra_valid_o
);

    localparam int PTR_W = $clog2(RAS_DEPTH);
    localparam int CNT_W = $clog2(RAS_DEPTH + 1);

    virt_t            stack_q [RAS_DEPTH];
    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] ptr_inc;
    logic [PTR_W-1:0] ptr_dec;
    logic [CNT_W-1:0] count_q;

    // ptr_q points at the next free slot, the top is one below it
    assign ptr_inc = (ptr_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : ptr_q + 1'b1;
    assign ptr_dec = (ptr_q == '0) ? PTR_W'(RAS_DEPTH - 1) : ptr_q - 1'b1;

    assign ra_o       = stack_q[ptr_dec];
    assign ra_valid_o = count_q != '0;

    always_ff @(posedge clk) begin
        if (~rst_n) begin
            ptr_q   <= '0;
            count_q <= '0;
        end else if (push_i) begin
            ptr_q <= ptr_inc;
            // on overflow the oldest return address is overwritten
            if (count_q != CNT_W'(RAS_DEPTH)) begin
                count_q <= count_q + 1'b1;
            end
        end else if (pop_i) begin
            ptr_q   <= ptr_dec;
            count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_q[ptr_q] <= push_pc_i;
        end
    end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> ra_valid_o);

endmodule

// File: logic/fetch1.sv
`timescale 1ns/10ps

module fetch1 import isa_pkg::*, frontend_pkg::*; #(
    parameter virt_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      rst_n,
    fetch_link_if.src link,
    input  logic      redirect_valid_i,
    input  virt_t     redirect_pc_i,
    output virt_t     btb_pc_o,
    input  logic      btb_hit_i,
    input  virt_t     btb_target_i,
    output logic      ar_valid_o,
    output virt_t     ar_addr_o,
    input  logic      ar_ready_i
);

    virt_t    pc_q;
    virt_t    ar_addr_q;
    logic     ar_wait_q;
    logic     ar_stale_q;
    logic     aligned;
    logic     kill;
    logic     issue;
    logic     ar_hs;
    logic     fetch_move;
    logic     excp_move;
    logic     move;
    next_pc_t pred;

    assign btb_pc_o = pc_q;
    assign aligned  = pc_q[1:0] == 2'b00;
    assign kill     = redirect_valid_i | link.flush;

    // ************************************************
    // AR issue
    // ************************************************

    // a request that was not accepted is held, even across a redirect
    assign issue      = ~ar_wait_q & ~link.stall & ~kill & aligned;
    assign ar_valid_o = ar_wait_q | issue;
    assign ar_addr_o  = ar_wait_q ? ar_addr_q : pc_q;
    assign ar_hs      = ar_valid_o & ar_ready_i;

    // a held read that outlived a redirect is still handed on, marked invalid
    assign fetch_move = ar_hs & ~ar_stale_q & ~redirect_valid_i;
    assign excp_move  = ~ar_wait_q & ~link.stall & ~kill & ~aligned;
    assign move       = fetch_move | excp_move;

    always_comb begin
        pred.is_predict = btb_hit_i;
        pred.pc         = btb_hit_i ? btb_target_i : pc_q + 32'd4;
    end

    always_comb begin
        link.pass.valid            = move;
        link.pass.pc               = pc_q;
        link.pass.next             = pred;
        link.pass.icache_wait_resp = ar_hs;
        link.excp.valid            = ~aligned;
        link.excp.excp_code        = EXCP_ADEF;
    end

    // ************************************************
    // pc register
    // ************************************************

    always_ff @(posedge clk) begin
        if (~rst_n) begin
            pc_q <= RESET_PC;
        end else if (redirect_valid_i) begin
            pc_q <= redirect_pc_i;
        end else if (link.wr_pc_req.valid) begin
            pc_q <= link.wr_pc_req.pc;
        end else if (move) begin
            pc_q <= pred.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (~rst_n) begin
            ar_wait_q  <= 1'b0;
            ar_stale_q <= 1'b0;
        end else begin
            ar_wait_q  <= ar_valid_o & ~ar_ready_i;
            ar_stale_q <= (ar_stale_q | redirect_valid_i) & ar_valid_o & ~ar_ready_i;
        end
    end

    always_ff @(posedge clk) begin
        if (~ar_wait_q) begin
            ar_addr_q <= pc_q;
        end
    end

    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

endmodule

// File: logic/fetch2.sv
`timescale 1ns/10ps

module fetch2 import isa_pkg::*, frontend_pkg::*; #(
    parameter int RAS_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    fetch_link_if.dst           link,
    input  logic                redirect_valid_i,
    input  logic                r_valid_i,
    input  u32_t                r_data_i,
    output logic                r_ready_o,
    input  logic                decode_ready_i,
    output btb_invalid_t        btb_invalid_o,
    output btb_update_t         btb_update_o,
    output fetch2_decode_pass_t pass_o,
    output excp_pass_t          excp_o
);

    localparam int DISCARD_W = 2;

    fetch1_fetch2_pass_t  pass_q;
    excp_pass_t           excp_q;
    logic [DISCARD_W-1:0] discard_q;

    logic    r_hs;
    logic    discarding;
    logic    live_resp;
    logic    stall;
    logic    load;
    logic    accept;
    logic    do_inst;
    logic    inc_redirect;
    logic    inc_stale;
    logic    dec_discard;
    u32_t    inst;
    opcode_t opcode;
    logic    is_b;
    logic    is_bl;
    logic    is_jump;
    logic    is_return;
    virt_t   seq_pc;
    virt_t   jump_to;
    virt_t   ra;
    logic    ra_valid;
    logic    bp_error;
    logic    bp_advance;
    logic    bp_repredict;
    logic    push;

    // ************************************************
    // stage register and response wait
    // ************************************************

    assign r_ready_o  = decode_ready_i;
    assign r_hs       = r_valid_i & r_ready_o;
    assign discarding = discard_q != '0;
    assign live_resp  = r_hs & ~discarding;

    assign stall      = pass_q.valid & (~decode_ready_i | (pass_q.icache_wait_resp & ~live_resp));
    assign link.stall = stall;
    assign load       = ~stall | redirect_valid_i;
    assign accept     = pass_q.valid & ~stall & ~redirect_valid_i;
    assign do_inst    = accept & ~excp_q.valid;

    always_ff @(posedge clk) begin
        if (~rst_n) begin
            pass_q.valid            <= 1'b0;
            pass_q.icache_wait_resp <= 1'b0;
            excp_q.valid            <= 1'b0;
        end else if (load) begin
            pass_q                  <= link.pass;
            pass_q.icache_wait_resp <= link.pass.icache_wait_resp & link.pass.valid;
            excp_q                  <= link.excp;
        end
    end

    // every read cut off by a redirect still returns one beat, which is dropped
    assign inc_redirect = redirect_valid_i & pass_q.valid & pass_q.icache_wait_resp & ~live_resp;
    assign inc_stale    = load & link.pass.icache_wait_resp & ~link.pass.valid;
    assign dec_discard  = r_hs & discarding;

    always_ff @(posedge clk) begin
        if (~rst_n) begin
            discard_q <= '0;
        end else begin
            discard_q <= discard_q + DISCARD_W'(inc_redirect) + DISCARD_W'(inc_stale)
                         - DISCARD_W'(dec_discard);
        end
    end

    // ************************************************
    // pre-decode and prediction correction
    // ************************************************

    assign inst      = r_data_i;
    assign opcode    = inst[OPC_MSB:OPC_LSB];
    assign is_b      = opcode == OP_B;
    assign is_bl     = opcode == OP_BL;
    assign is_jump   = is_b | is_bl;
    assign is_return = inst == INST_RETURN;

    assign seq_pc  = pass_q.pc + 32'd4;
    assign jump_to = pass_q.pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    // conditional branches are predicted not taken, so they count as straight-line here
    assign bp_error     = do_inst & pass_q.next.is_predict & ~is_jump & ~is_return
                          & (pass_q.next.pc != seq_pc);
    assign bp_advance   = do_inst & is_jump
                          & ~(pass_q.next.is_predict & (pass_q.next.pc == jump_to));
    assign bp_repredict = do_inst & is_return & ra_valid;
    assign push         = do_inst & is_bl;

    ras #(
        .RAS_DEPTH(RAS_DEPTH)
    ) u_ras (
        .clk       (clk),
        .rst_n     (rst_n),
        .push_i    (push),
        .push_pc_i (seq_pc),
        .pop_i     (bp_repredict),
        .ra_o      (ra),
        .ra_valid_o(ra_valid)
    );

    assign link.flush = bp_error | bp_advance | bp_repredict;

    always_comb begin
        pass_o.valid   = do_inst;
        pass_o.pc      = pass_q.pc;
        pass_o.inst    = inst;
        pass_o.next    = pass_q.next;
        link.wr_pc_req = '0;
        if (bp_error) begin
            pass_o.next    = '{pc: seq_pc, is_predict: 1'b0};
            link.wr_pc_req = '{valid: 1'b1, pc: seq_pc, is_predict: 1'b0};
        end else if (bp_advance) begin
            pass_o.next    = '{pc: jump_to, is_predict: 1'b0};
            link.wr_pc_req = '{valid: 1'b1, pc: jump_to, is_predict: 1'b0};
        end else if (bp_repredict) begin
            pass_o.next    = '{pc: ra, is_predict: 1'b1};
            link.wr_pc_req = '{valid: 1'b1, pc: ra, is_predict: 1'b1};
        end
    end

    always_comb begin
        excp_o.valid        = accept & excp_q.valid;
        excp_o.excp_code    = excp_q.excp_code;
        btb_invalid_o.valid = bp_error;
        btb_invalid_o.pc    = pass_q.pc;
        btb_update_o.valid  = bp_advance;
        btb_update_o.pc     = pass_q.pc;
        btb_update_o.target = jump_to;
    end

endmodule

// File: logic/frontend_top.sv
`timescale 1ns/10ps

module frontend_top import isa_pkg::*, frontend_pkg::*; #(
    parameter int    BTB_ENTRIES = 64,
    parameter int    RAS_DEPTH   = 8,
    parameter virt_t RESET_PC    = '0
) (
    input  logic       clk,
    input  logic       rst_n,
    output logic       ar_valid_o,
    output virt_t      ar_addr_o,
    output logic [2:0] ar_prot_o,
    input  logic       ar_ready_i,
    input  logic       r_valid_i,
    input  u32_t       r_data_i,
    input  logic [1:0] r_resp_i,
    output logic       r_ready_o,
    input  logic       redirect_valid_i,
    input  virt_t      redirect_pc_i,
    input  logic       decode_ready_i,
    output logic       inst_valid_o,
    output u32_t       inst_o,
    output virt_t      inst_pc_o,
    output virt_t      next_pc_o,
    output logic       next_predict_o,
    output logic       excp_valid_o,
    output excp_code_t excp_code_o
);

    virt_t               btb_pc;
    logic                btb_hit;
    virt_t               btb_target;
    btb_invalid_t        btb_invalid;
    btb_update_t         btb_update;
    fetch2_decode_pass_t dec_pass;
    excp_pass_t          dec_excp;

    fetch_link_if link ();

    // instruction, unprivileged, secure
    assign ar_prot_o = 3'b100;

    fetch1 #(
        .RESET_PC(RESET_PC)
    ) u_fetch1 (
        .clk             (clk),
        .rst_n           (rst_n),
        .link            (link),
        .redirect_valid_i(redirect_valid_i),
        .redirect_pc_i   (redirect_pc_i),
        .btb_pc_o        (btb_pc),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .ar_valid_o      (ar_valid_o),
        .ar_addr_o       (ar_addr_o),
        .ar_ready_i      (ar_ready_i)
    );

    btb #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) u_btb (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_pc_i(btb_pc),
        .hit_o      (btb_hit),
        .target_o   (btb_target),
        .update_i   (btb_update),
        .invalid_i  (btb_invalid)
    );

    fetch2 #(
        .RAS_DEPTH(RAS_DEPTH)
    ) u_fetch2 (
        .clk             (clk),
        .rst_n           (rst_n),
        .link            (link),
        .redirect_valid_i(redirect_valid_i),
        .r_valid_i       (r_valid_i),
        .r_data_i        (r_data_i),
        .r_ready_o       (r_ready_o),
        .decode_ready_i  (decode_ready_i),
        .btb_invalid_o   (btb_invalid),
        .btb_update_o    (btb_update),
        .pass_o          (dec_pass),
        .excp_o          (dec_excp)
    );

    assign inst_valid_o   = dec_pass.valid;
    assign inst_o         = dec_pass.inst;
    assign inst_pc_o      = dec_pass.pc;
    assign next_pc_o      = dec_pass.next.pc;
    assign next_predict_o = dec_pass.next.is_predict;
    assign excp_valid_o   = dec_excp.valid;
    assign excp_code_o    = dec_excp.excp_code;

endmodule

// File: bench/frontend_ref.svh
`ifndef FRONTEND_REF_SVH
`define FRONTEND_REF_SVH

// **************************************************
// instruction memory and program builders
// **************************************************

u32_t  mem [1024];
virt_t ras_model [$];
int    errors = 0;

// opcode 0x01 is no branch, the other fields spread the word index
function automatic u32_t fill_word(int idx);
    return {6'h01, 10'(idx * 7), 6'(idx >> 4), 10'(idx)};
endfunction

task automatic fill_memory();
    for (int i = 0; i < 1024; i++) begin
        mem[i] = fill_word(i);
    end
endtask

function automatic u32_t jump_word(opcode_t op, virt_t pc, virt_t target);
    virt_t offs;
    offs = (target - pc) >> 2;
    return {op, offs[15:0], offs[25:16]};
endfunction

task automatic put_word(virt_t pc, u32_t word);
    mem[pc[11:2]] = word;
endtask

task automatic put_jump(opcode_t op, virt_t pc, virt_t target);
    put_word(pc, jump_word(op, pc, target));
endtask

// **************************************************
// reference next pc
// **************************************************

function automatic logic is_jump_word(u32_t w);
    return (w[31:26] == OP_B) || (w[31:26] == OP_BL);
endfunction

// the model stack is updated as each instruction is retired by decode
function automatic next_pc_t expected_next(virt_t pc, u32_t w);
    next_pc_t    nxt;
    logic [25:0] offs;
    offs           = {w[9:0], w[25:10]};
    nxt.pc         = pc + 32'd4;
    nxt.is_predict = 1'b0;
    if (is_jump_word(w)) begin
        nxt.pc = pc + {{4{offs[25]}}, offs, 2'b00};
        if (w[31:26] == OP_BL) begin
            ras_model.push_back(pc + 32'd4);
        end
    end else if (w == INST_RETURN && ras_model.size() > 0) begin
        nxt.pc         = ras_model.pop_back();
        nxt.is_predict = 1'b1;
    end
    return nxt;
endfunction

// **************************************************
// compare tasks
// **************************************************

task automatic check_virt(string name, virt_t got, virt_t exp);
    if (got !== exp) begin
        $display("FAIL %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic check_word(string name, u32_t got, u32_t exp);
    if (got !== exp) begin
        $display("FAIL %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
        $display("FAIL %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic check_prot(string name, logic [2:0] got, logic [2:0] exp);
    if (got !== exp) begin
        $display("FAIL %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic check_excp(string name, excp_pass_t got, excp_pass_t exp);
    if (got !== exp) begin
        $display("FAIL %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic report_error(string msg);
    $display("error: %s", msg);
    errors++;
endtask

`endif

// File: bench/frontend_tb.sv
`timescale 1ns/10ps

module frontend_tb import isa_pkg::*, frontend_pkg::*; ();

    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 400;

    // AxPROT bit 2 marks an instruction access, the other bits stay low
    localparam logic [2:0] PROT_INST = 3'b100;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       ar_valid_o;
    virt_t      ar_addr_o;
    logic [2:0] ar_prot_o;
    logic       ar_ready_i;
    logic       r_valid_i;
    u32_t       r_data_i;
    logic [1:0] r_resp_i;
    logic       r_ready_o;
    logic       redirect_valid_i;
    virt_t      redirect_pc_i;
    logic       decode_ready_i;
    logic       inst_valid_o;
    u32_t       inst_o;
    virt_t      inst_pc_o;
    virt_t      next_pc_o;
    logic       next_predict_o;
    logic       excp_valid_o;
    excp_code_t excp_code_o;

    integer     seed = 21138;
    logic       jitter = 1'b0;
    logic       hold_r = 1'b0;
    logic       r_taken = 1'b0;
    int         hold_at = -1;
    virt_t      rd_q [$];
    int         r_wait = 0;
    int         ar_count = 0;
    int         cycles = 0;
    virt_t      exp_pc = '0;
    virt_t      stop_pc = '1;
    logic       stopped = 1'b0;
    logic       jumps_learned = 1'b0;
    logic       excp_expected = 1'b0;
    logic       excp_seen = 1'b0;
    excp_pass_t excp_got;
    virt_t      excp_pc;
    u32_t       word;
    next_pc_t   nxt;
    int         test_num = 0;
    int         tests_failed = 0;
    int         errors_before = 0;

    `include "frontend_ref.svh"

    frontend_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .ar_valid_o      (ar_valid_o),
        .ar_addr_o       (ar_addr_o),
        .ar_prot_o       (ar_prot_o),
        .ar_ready_i      (ar_ready_i),
        .r_valid_i       (r_valid_i),
        .r_data_i        (r_data_i),
        .r_resp_i        (r_resp_i),
        .r_ready_o       (r_ready_o),
        .redirect_valid_i(redirect_valid_i),
        .redirect_pc_i   (redirect_pc_i),
        .decode_ready_i  (decode_ready_i),
        .inst_valid_o    (inst_valid_o),
        .inst_o          (inst_o),
        .inst_pc_o       (inst_pc_o),
        .next_pc_o       (next_pc_o),
        .next_predict_o  (next_predict_o),
        .excp_valid_o    (excp_valid_o),
        .excp_code_o     (excp_code_o)
    );

    always #2 clk = ~clk;

    // **************************************************
    // AXI memory responder
    // **************************************************

    always @(posedge clk) begin
        if (rst_n) begin
            check_flag("r_ready_o", r_ready_o, decode_ready_i);
        end
        if (rst_n && ar_valid_o && ar_ready_i) begin
            rd_q.push_back(ar_addr_o);
            ar_count++;
            check_prot("ar_prot_o", ar_prot_o, PROT_INST);
            if (ar_count == hold_at) begin
                hold_r = 1'b1;
            end
            if (ar_addr_o[1:0] != 2'b00) begin
                report_error("a read was issued for a misaligned pc");
            end
        end
        if (r_valid_i && r_ready_o) begin
            r_taken = 1'b1;
        end
    end

    // all DUT inputs except reset and redirect change here
    always @(negedge clk) begin
        if (r_taken) begin
            r_valid_i = 1'b0;
            r_taken   = 1'b0;
        end
        if (!r_valid_i && rd_q.size() > 0 && !hold_r) begin
            if (r_wait > 0) begin
                r_wait--;
            end else begin
                r_data_i  = mem[rd_q.pop_front() >> 2];
                r_valid_i = 1'b1;
                r_wait    = jitter ? ($random(seed) & 3) : 0;
            end
        end
        ar_ready_i     = rst_n && (!jitter || (($random(seed) & 1) != 0));
        decode_ready_i = !jitter || (($random(seed) & 3) != 0);
    end

    // **************************************************
    // compare process and timeout
    // **************************************************

    always @(posedge clk) begin
        if (rst_n && inst_valid_o) begin
            word = mem[exp_pc[11:2]];
            nxt  = expected_next(exp_pc, word);
            check_virt("inst_pc_o", inst_pc_o, exp_pc);
            check_word("inst_o", inst_o, word);
            check_virt("next_pc_o", next_pc_o, nxt.pc);
            // a b or bl is predicted by the BTB once an earlier pass has taught it
            if (!is_jump_word(word)) begin
                check_flag("next_predict_o", next_predict_o, nxt.is_predict);
            end else if (jumps_learned) begin
                check_flag("next_predict_o", next_predict_o, 1'b1);
            end
            if (exp_pc == stop_pc) begin
                stopped = 1'b1;
            end
            exp_pc = nxt.pc;
        end
        if (rst_n && excp_valid_o) begin
            if (!excp_expected) begin
                report_error("an exception was raised where none was due");
            end else if (!excp_seen) begin
                excp_got = '{valid: 1'b1, excp_code: excp_code_o};
                excp_pc  = inst_pc_o;
            end
            excp_seen = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a test never finished", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // **************************************************
    // test sequencing
    // **************************************************

    task automatic redirect_to(virt_t pc);
        @(negedge clk);
        redirect_valid_i = 1'b1;
        redirect_pc_i    = pc;
        exp_pc           = pc;
        stopped          = 1'b0;
        @(negedge clk);
        redirect_valid_i = 1'b0;
    endtask

    task automatic run_program(virt_t start, virt_t stop);
        stop_pc = stop;
        redirect_to(start);
        while (!stopped) begin
            @(posedge clk);
        end
    endtask

    task automatic start_test();
        errors_before = errors;
        test_num++;
    endtask

    task automatic end_test(string name);
        if (errors == errors_before) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - errors_before);
            tests_failed++;
        end
    endtask

    // every program ends in a b to itself so fetch spins there between tests
    task automatic build_programs();
        fill_memory();
        put_jump(OP_B, 32'h000, 32'h000);
        put_jump(OP_B, 32'h130, 32'h130);
        put_jump(OP_B, 32'h204, 32'h210);
        put_jump(OP_BL, 32'h210, 32'h240);
        put_word(32'h244, INST_RETURN);
        put_jump(OP_B, 32'h214, 32'h260);
        put_jump(OP_B, 32'h260, 32'h260);
        put_jump(OP_BL, 32'h300, 32'h320);
        put_jump(OP_B, 32'h304, 32'h304);
        put_jump(OP_BL, 32'h324, 32'h340);
        put_word(32'h328, INST_RETURN);
        put_jump(OP_BL, 32'h344, 32'h360);
        put_word(32'h348, INST_RETURN);
        put_word(32'h364, INST_RETURN);
        put_jump(OP_B, 32'h404, 32'h420);
        put_jump(OP_B, 32'h420, 32'h440);
        put_jump(OP_B, 32'h440, 32'h440);
    endtask

    initial begin
        rst_n            = 1'b0;
        ar_ready_i       = 1'b0;
        r_valid_i        = 1'b0;
        r_data_i         = '0;
        r_resp_i         = 2'b00;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        decode_ready_i   = 1'b1;
        build_programs();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        start_test();
        run_program(32'h100, 32'h130);
        end_test("straight line");

        start_test();
        run_program(32'h200, 32'h260);
        jumps_learned = 1'b1;
        run_program(32'h200, 32'h260);
        jumps_learned = 1'b0;
        end_test("b and bl loop over two passes");

        start_test();
        run_program(32'h300, 32'h304);
        end_test("nested calls and returns");

        start_test();
        run_program(32'h400, 32'h440);
        put_word(32'h404, fill_word(32'h404 >> 2));
        jumps_learned = 1'b1;
        run_program(32'h400, 32'h440);
        jumps_learned = 1'b0;
        end_test("learned b rewritten to a non-branch");

        // hold the fourth read of the straight line and redirect over it
        start_test();
        jitter = 1'b1;
        run_program(32'h300, 32'h304);
        run_program(32'h200, 32'h260);
        hold_at = ar_count + 4;
        stop_pc = 32'h304;
        redirect_to(32'h100);
        while (!hold_r) begin
            @(posedge clk);
        end
        redirect_to(32'h300);
        hold_r  = 1'b0;
        hold_at = -1;
        while (!stopped) begin
            @(posedge clk);
        end
        jitter = 1'b0;
        end_test("random delays and redirect during a read");

        start_test();
        excp_expected = 1'b1;
        excp_seen     = 1'b0;
        redirect_to(32'h502);
        while (!excp_seen) begin
            @(posedge clk);
        end
        check_excp("excp", excp_got, '{valid: 1'b1, excp_code: EXCP_ADEF});
        check_virt("inst_pc_o", excp_pc, 32'h502);
        stop_pc = 32'h130;
        redirect_to(32'h100);
        excp_expected = 1'b0;
        while (!stopped) begin
            @(posedge clk);
        end
        end_test("misaligned redirect");

        $display("tests run %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+bench
logic/isa_pkg.sv
logic/frontend_pkg.sv
logic/fetch_link_if.sv
logic/btb.sv
logic/ras.sv
logic/fetch1.sv
logic/fetch2.sv
logic/frontend_top.sv
bench/frontend_tb.sv

// File: Makefile
SIM        = verilator
TOP        = frontend_tb
RTL_TOP    = frontend_top
FILELIST   = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FLAGS      = --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
